//--- logic/vector_cache_defs.svh
`ifndef VECTOR_CACHE_DEFS_SVH
`define VECTOR_CACHE_DEFS_SVH

// fabric geometry
`define VC_LANES        2
`define VC_BANKS        4
`define VC_WORDS        16

// payload widths
`define VC_DATA_W       32
`define VC_TAG_W        6

// local read data waiting for a free westbound slot
`define VC_MERGE_DEPTH  4

`endif

//--- logic/fabric_route_pkg.sv
`default_nettype none

`include "vector_cache_defs.svh"

package fabric_route_pkg;

    typedef logic [2:0]                   ram_col_t;  // may point past the row
    typedef logic [$clog2(`VC_WORDS)-1:0] ram_word_t;

    typedef struct packed {
        ram_col_t  col;
        ram_word_t word;
    } ram_route_t;

    // same 7 bits, seen as column/word or as one global index
    typedef union packed {
        ram_route_t                   route;
        logic [$bits(ram_route_t)-1:0] flat;
    } ram_addr_u;

endpackage

`default_nettype wire

//--- logic/cache_cmd_pkg.sv
`default_nettype none

`include "vector_cache_defs.svh"

package cache_cmd_pkg;

    typedef struct packed {
        fabric_route_pkg::ram_addr_u dest_ram_id;
        logic [`VC_TAG_W-1:0]        tag;
    } arb_out_req_t;

    typedef struct packed {
        fabric_route_pkg::ram_addr_u dest_ram_id;
        logic [`VC_DATA_W-1:0]       wdata;
    } write_ram_cmd_t;

    // read response, tag echoed from the request
    typedef struct packed {
        logic [`VC_TAG_W-1:0]  tag;
        logic [`VC_DATA_W-1:0] data;
    } data_pld_t;

endpackage

`default_nettype wire

//--- logic/mem_block.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_defs.svh"

module mem_block #(
    parameter int unsigned BLOCK_ID = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [`VC_LANES-1:0]          west_read_cmd_vld_in,
    input  cache_cmd_pkg::arb_out_req_t   west_read_cmd_pld_in   [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]          west_write_cmd_vld_in,
    input  cache_cmd_pkg::write_ram_cmd_t west_write_cmd_pld_in  [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          east_read_cmd_vld_out,
    output cache_cmd_pkg::arb_out_req_t   east_read_cmd_pld_out  [`VC_LANES-1:0],
    output logic [`VC_LANES-1:0]          east_write_cmd_vld_out,
    output cache_cmd_pkg::write_ram_cmd_t east_write_cmd_pld_out [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          east_data_out_vld,
    output cache_cmd_pkg::data_pld_t      east_data_out          [`VC_LANES-1:0],

    input  logic [`VC_LANES-1:0]          east_data_in_vld,
    input  cache_cmd_pkg::data_pld_t      east_data_in           [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          west_data_out_vld,
    output cache_cmd_pkg::data_pld_t      west_data_out          [`VC_LANES-1:0]
);

    localparam fabric_route_pkg::ram_col_t MY_COL = fabric_route_pkg::ram_col_t'(BLOCK_ID);

    logic [`VC_DATA_W-1:0] mem [`VC_LANES-1:0][`VC_WORDS-1:0];

    logic [`VC_LANES-1:0] rd_hit;
    logic [`VC_LANES-1:0] wr_hit;

    genvar i;
    generate
        for (i = 0; i < `VC_LANES; i = i + 1) begin : gen_lane
            fabric_route_pkg::ram_addr_u rd_addr;
            fabric_route_pkg::ram_addr_u wr_addr;

            assign rd_addr = west_read_cmd_pld_in[i].dest_ram_id;
            assign wr_addr = west_write_cmd_pld_in[i].dest_ram_id;

            assign rd_hit[i] = west_read_cmd_vld_in[i] && (rd_addr.route.col == MY_COL);
            assign wr_hit[i] = west_write_cmd_vld_in[i] && (wr_addr.route.col == MY_COL);

            always_ff @(posedge clk) begin
                if (wr_hit[i]) begin
                    mem[i][wr_addr.route.word] <= west_write_cmd_pld_in[i].wdata;
                end

                // read sees the word as it was before a same-cycle write
                if (rd_hit[i]) begin
                    east_data_out[i].tag  <= west_read_cmd_pld_in[i].tag;
                    east_data_out[i].data <= mem[i][rd_addr.route.word];
                end

                east_read_cmd_pld_out[i]  <= west_read_cmd_pld_in[i];
                east_write_cmd_pld_out[i] <= west_write_cmd_pld_in[i];
                west_data_out[i]          <= east_data_in[i];  // merged data, one stage
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            east_read_cmd_vld_out  <= '0;
            east_write_cmd_vld_out <= '0;
            east_data_out_vld      <= '0;
            west_data_out_vld      <= '0;
        end else begin
            east_read_cmd_vld_out  <= west_read_cmd_vld_in & ~rd_hit;   // hits are consumed here
            east_write_cmd_vld_out <= west_write_cmd_vld_in & ~wr_hit;
            east_data_out_vld      <= rd_hit;
            west_data_out_vld      <= east_data_in_vld;
        end
    end

endmodule

`default_nettype wire

//--- logic/xy_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_defs.svh"

module xy_switch (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [`VC_LANES-1:0]          west_read_cmd_in_vld,
    input  cache_cmd_pkg::arb_out_req_t   west_read_cmd_in_pld   [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]          west_write_cmd_in_vld,
    input  cache_cmd_pkg::write_ram_cmd_t west_write_cmd_in_pld  [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          east_read_cmd_out_vld,
    output cache_cmd_pkg::arb_out_req_t   east_read_cmd_out_pld  [`VC_LANES-1:0],
    output logic [`VC_LANES-1:0]          east_write_cmd_out_vld,
    output cache_cmd_pkg::write_ram_cmd_t east_write_cmd_out_pld [`VC_LANES-1:0],

    input  logic [`VC_LANES-1:0]          west_data_in_vld,      // local read data
    input  cache_cmd_pkg::data_pld_t      west_data_in           [`VC_LANES-1:0],

    input  logic [`VC_LANES-1:0]          east_data_in_vld,      // through data
    input  cache_cmd_pkg::data_pld_t      east_data_in           [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          west_data_out_vld,
    output cache_cmd_pkg::data_pld_t      west_data_out          [`VC_LANES-1:0]
);

    localparam int DEPTH = `VC_MERGE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cache_cmd_pkg::data_pld_t q_mem [`VC_LANES-1:0][DEPTH-1:0];

    logic [PTR_W-1:0] q_wr_ptr [`VC_LANES-1:0];
    logic [PTR_W-1:0] q_rd_ptr [`VC_LANES-1:0];
    logic [CNT_W-1:0] q_count  [`VC_LANES-1:0];

    logic [`VC_LANES-1:0] q_push;
    logic [`VC_LANES-1:0] q_pop;
    logic [`VC_LANES-1:0] bypass;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // command path, one register per hop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            east_read_cmd_out_vld  <= '0;
            east_write_cmd_out_vld <= '0;
            west_data_out_vld      <= '0;
        end else begin
            east_read_cmd_out_vld  <= west_read_cmd_in_vld;
            east_write_cmd_out_vld <= west_write_cmd_in_vld;
            west_data_out_vld      <= east_data_in_vld | q_pop | bypass;
        end
    end

    genvar i;
    generate
        for (i = 0; i < `VC_LANES; i = i + 1) begin : gen_lane
            // through data owns the slot; queued local data drains first
            assign q_pop[i]  = !east_data_in_vld[i] && (q_count[i] != '0);
            assign bypass[i] = west_data_in_vld[i] && !east_data_in_vld[i] && (q_count[i] == '0);
            assign q_push[i] = west_data_in_vld[i] && !bypass[i]
                               && ((q_count[i] != CNT_W'(DEPTH)) || q_pop[i]);

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    q_wr_ptr[i] <= '0;
                    q_rd_ptr[i] <= '0;
                    q_count[i]  <= '0;
                end else begin
                    if (q_push[i]) begin
                        q_wr_ptr[i] <= ptr_inc(q_wr_ptr[i]);
                    end
                    if (q_pop[i]) begin
                        q_rd_ptr[i] <= ptr_inc(q_rd_ptr[i]);
                    end
                    case ({q_push[i], q_pop[i]})
                        2'b10:   q_count[i] <= q_count[i] + 1'b1;
                        2'b01:   q_count[i] <= q_count[i] - 1'b1;
                        default: q_count[i] <= q_count[i];
                    endcase
                end
            end

            always_ff @(posedge clk) begin
                east_read_cmd_out_pld[i]  <= west_read_cmd_in_pld[i];
                east_write_cmd_out_pld[i] <= west_write_cmd_in_pld[i];

                if (q_push[i]) begin
                    q_mem[i][q_wr_ptr[i]] <= west_data_in[i];
                end

                if (east_data_in_vld[i]) begin
                    west_data_out[i] <= east_data_in[i];
                end else if (q_pop[i]) begin
                    west_data_out[i] <= q_mem[i][q_rd_ptr[i]];
                end else begin
                    west_data_out[i] <= west_data_in[i];  // bypass or idle
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- logic/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_defs.svh"

module sram_bank #(
    parameter int unsigned BLOCK_ID = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [`VC_LANES-1:0]          west_read_cmd_vld_in,
    input  cache_cmd_pkg::arb_out_req_t   west_read_cmd_pld_in   [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]          west_write_cmd_vld_in,
    input  cache_cmd_pkg::write_ram_cmd_t west_write_cmd_pld_in  [`VC_LANES-1:0],
    output logic [`VC_LANES-1:0]          west_data_out_vld,
    output cache_cmd_pkg::data_pld_t      west_data_out          [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          east_read_cmd_vld_out,
    output cache_cmd_pkg::arb_out_req_t   east_read_cmd_pld_out  [`VC_LANES-1:0],
    output logic [`VC_LANES-1:0]          east_write_cmd_vld_out,
    output cache_cmd_pkg::write_ram_cmd_t east_write_cmd_pld_out [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]          east_data_in_vld,
    input  cache_cmd_pkg::data_pld_t      east_data_in           [`VC_LANES-1:0]
);

    logic [`VC_LANES-1:0]          mem_east_read_cmd_out_vld;
    cache_cmd_pkg::arb_out_req_t   mem_east_read_cmd_out_pld  [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          mem_east_write_cmd_out_vld;
    cache_cmd_pkg::write_ram_cmd_t mem_east_write_cmd_out_pld [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          mem_east_data_out_vld;       // local read data
    cache_cmd_pkg::data_pld_t      mem_east_data_out          [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          switch_west_data_out_vld;    // merged stream
    cache_cmd_pkg::data_pld_t      switch_west_data_out       [`VC_LANES-1:0];

    mem_block #(
        .BLOCK_ID (BLOCK_ID)
    ) u_mem_block (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .west_read_cmd_vld_in   (west_read_cmd_vld_in),
        .west_read_cmd_pld_in   (west_read_cmd_pld_in),
        .west_write_cmd_vld_in  (west_write_cmd_vld_in),
        .west_write_cmd_pld_in  (west_write_cmd_pld_in),
        .east_read_cmd_vld_out  (mem_east_read_cmd_out_vld),
        .east_read_cmd_pld_out  (mem_east_read_cmd_out_pld),
        .east_write_cmd_vld_out (mem_east_write_cmd_out_vld),
        .east_write_cmd_pld_out (mem_east_write_cmd_out_pld),
        .east_data_out_vld      (mem_east_data_out_vld),
        .east_data_out          (mem_east_data_out),
        .east_data_in_vld       (switch_west_data_out_vld),
        .east_data_in           (switch_west_data_out),
        .west_data_out_vld      (west_data_out_vld),
        .west_data_out          (west_data_out)
    );

    xy_switch u_xy_switch (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .west_read_cmd_in_vld   (mem_east_read_cmd_out_vld),
        .west_read_cmd_in_pld   (mem_east_read_cmd_out_pld),
        .west_write_cmd_in_vld  (mem_east_write_cmd_out_vld),
        .west_write_cmd_in_pld  (mem_east_write_cmd_out_pld),
        .east_read_cmd_out_vld  (east_read_cmd_vld_out),
        .east_read_cmd_out_pld  (east_read_cmd_pld_out),
        .east_write_cmd_out_vld (east_write_cmd_vld_out),
        .east_write_cmd_out_pld (east_write_cmd_pld_out),
        .west_data_in_vld       (mem_east_data_out_vld),
        .west_data_in           (mem_east_data_out),
        .east_data_in_vld       (east_data_in_vld),
        .east_data_in           (east_data_in),
        .west_data_out_vld      (switch_west_data_out_vld),
        .west_data_out          (switch_west_data_out)
    );

endmodule

`default_nettype wire

//--- logic/vector_cache_row.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_defs.svh"

module vector_cache_row (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [`VC_LANES-1:0]          west_read_cmd_vld_in,
    input  cache_cmd_pkg::arb_out_req_t   west_read_cmd_pld_in   [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]          west_write_cmd_vld_in,
    input  cache_cmd_pkg::write_ram_cmd_t west_write_cmd_pld_in  [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          west_data_out_vld,
    output cache_cmd_pkg::data_pld_t      west_data_out          [`VC_LANES-1:0],

    output logic [`VC_LANES-1:0]          east_read_cmd_vld_out,
    output cache_cmd_pkg::arb_out_req_t   east_read_cmd_pld_out  [`VC_LANES-1:0],
    output logic [`VC_LANES-1:0]          east_write_cmd_vld_out,
    output cache_cmd_pkg::write_ram_cmd_t east_write_cmd_pld_out [`VC_LANES-1:0]
);

    // index b is the west edge of bank b
    logic [`VC_LANES-1:0]          rd_vld   [`VC_BANKS:0];
    cache_cmd_pkg::arb_out_req_t   rd_pld   [`VC_BANKS:0][`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          wr_vld   [`VC_BANKS:0];
    cache_cmd_pkg::write_ram_cmd_t wr_pld   [`VC_BANKS:0][`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          data_vld [`VC_BANKS:0];
    cache_cmd_pkg::data_pld_t      data     [`VC_BANKS:0][`VC_LANES-1:0];

    assign rd_vld[0]              = west_read_cmd_vld_in;
    assign wr_vld[0]              = west_write_cmd_vld_in;
    assign east_read_cmd_vld_out  = rd_vld[`VC_BANKS];
    assign east_write_cmd_vld_out = wr_vld[`VC_BANKS];
    assign west_data_out_vld      = data_vld[0];
    assign data_vld[`VC_BANKS]    = '0;  // nothing beyond the last bank

    genvar b, l;
    generate
        for (l = 0; l < `VC_LANES; l = l + 1) begin : gen_edge
            assign rd_pld[0][l]            = west_read_cmd_pld_in[l];
            assign wr_pld[0][l]            = west_write_cmd_pld_in[l];
            assign east_read_cmd_pld_out[l]  = rd_pld[`VC_BANKS][l];
            assign east_write_cmd_pld_out[l] = wr_pld[`VC_BANKS][l];
            assign west_data_out[l]        = data[0][l];
            assign data[`VC_BANKS][l]      = '0;
        end

        for (b = 0; b < `VC_BANKS; b = b + 1) begin : gen_bank
            sram_bank #(
                .BLOCK_ID (b)
            ) u_sram_bank (
                .clk                    (clk),
                .rst_n                  (rst_n),
                .west_read_cmd_vld_in   (rd_vld[b]),
                .west_read_cmd_pld_in   (rd_pld[b]),
                .west_write_cmd_vld_in  (wr_vld[b]),
                .west_write_cmd_pld_in  (wr_pld[b]),
                .west_data_out_vld      (data_vld[b]),
                .west_data_out          (data[b]),
                .east_read_cmd_vld_out  (rd_vld[b+1]),
                .east_read_cmd_pld_out  (rd_pld[b+1]),
                .east_write_cmd_vld_out (wr_vld[b+1]),
                .east_write_cmd_pld_out (wr_pld[b+1]),
                .east_data_in_vld       (data_vld[b+1]),
                .east_data_in           (data[b+1])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- test/vector_cache_row_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_defs.svh"

module vector_cache_row_assert (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`VC_LANES-1:0]     east_read_cmd_out_vld,
    input  logic [`VC_LANES-1:0]     east_write_cmd_out_vld,
    input  logic [`VC_LANES-1:0]     west_data_out_vld,
    input  cache_cmd_pkg::data_pld_t west_data_out [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]     west_data_in_vld,
    input  logic [`VC_LANES-1:0]     east_data_in_vld,
    input  cache_cmd_pkg::data_pld_t east_data_in  [`VC_LANES-1:0],
    input  logic [`VC_LANES-1:0]     q_push,
    input  logic [`VC_LANES-1:0]     bypass
);

    reset_clears_valids: assert property (@(posedge clk)
        !rst_n |=> (west_data_out_vld == '0 && east_read_cmd_out_vld == '0
                    && east_write_cmd_out_vld == '0))
        else $error("switch valid output high in the cycle after reset");

    genvar i;
    generate
        for (i = 0; i < `VC_LANES; i = i + 1) begin : gen_lane
            // local data leaves at once or gets a queue slot
            no_queue_overflow: assert property (@(posedge clk) disable iff (!rst_n)
                west_data_in_vld[i] |-> (bypass[i] || q_push[i]))
                else $error("merge queue overflow on lane %0d", i);

            through_data_kept: assert property (@(posedge clk) disable iff (!rst_n)
                east_data_in_vld[i] |=> (west_data_out_vld[i]
                                         && west_data_out[i] == $past(east_data_in[i])))
                else $error("through data dropped on lane %0d", i);
        end
    endgenerate

endmodule

bind xy_switch vector_cache_row_assert u_switch_assert (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .east_read_cmd_out_vld  (east_read_cmd_out_vld),
    .east_write_cmd_out_vld (east_write_cmd_out_vld),
    .west_data_out_vld      (west_data_out_vld),
    .west_data_out          (west_data_out),
    .west_data_in_vld       (west_data_in_vld),
    .east_data_in_vld       (east_data_in_vld),
    .east_data_in           (east_data_in),
    .q_push                 (q_push),
    .bypass                 (bypass)
);

`default_nettype wire

//--- test/vector_cache_row_tb.sv
`timescale 1ns/1ps

`include "vector_cache_defs.svh"

`default_nettype none

module vector_cache_row_tb;

    localparam int FLAT_N      = 1 << $bits(fabric_route_pkg::ram_addr_u);
    localparam int TAGS        = 1 << `VC_TAG_W;
    localparam int WDOG_MARGIN = 100;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic [`VC_LANES-1:0]          west_read_cmd_vld_in;
    cache_cmd_pkg::arb_out_req_t   west_read_cmd_pld_in   [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          west_write_cmd_vld_in;
    cache_cmd_pkg::write_ram_cmd_t west_write_cmd_pld_in  [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          west_data_out_vld;
    cache_cmd_pkg::data_pld_t      west_data_out          [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          east_read_cmd_vld_out;
    cache_cmd_pkg::arb_out_req_t   east_read_cmd_pld_out  [`VC_LANES-1:0];
    logic [`VC_LANES-1:0]          east_write_cmd_vld_out;
    cache_cmd_pkg::write_ram_cmd_t east_write_cmd_pld_out [`VC_LANES-1:0];

    // reference memory, one flat space per lane
    logic [`VC_DATA_W-1:0] model    [`VC_LANES][FLAT_N];
    logic [`VC_DATA_W-1:0] exp_data [`VC_LANES][TAGS];
    bit                    exp_pend [`VC_LANES][TAGS];

    int next_tag [`VC_LANES];
    int outstanding = 0;
    int n_issued    = 0;
    int cycles      = 0;
    int seed        = 32'h2a13754a;
    bit east_open   = 1'b0;  // east edge traffic expected

    vector_cache_row dut_i (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at first failure");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > n_issued * (3 + 4 * `VC_BANKS) + WDOG_MARGIN) begin
            fail_run($sformatf("timeout: run still busy after %0d cycles", cycles));
        end
    end

    function automatic fabric_route_pkg::ram_addr_u mk_addr(input int col, input int word);
        fabric_route_pkg::ram_addr_u a;
        a.route.col  = fabric_route_pkg::ram_col_t'(col);
        a.route.word = fabric_route_pkg::ram_word_t'(word);
        return a;
    endfunction

    task automatic check_data(input int lane, input cache_cmd_pkg::data_pld_t got);
        if (!exp_pend[lane][got.tag]) begin
            fail_run($sformatf("west_data_out[%0d] carries unknown tag %h", lane, got.tag));
        end else if (got.data !== exp_data[lane][got.tag]) begin
            fail_run($sformatf("Error: west_data_out[%0d] tag %h got %h expected %h",
                               lane, got.tag, got.data, exp_data[lane][got.tag]));
        end else begin
            exp_pend[lane][got.tag] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic check_read_cmd(input int lane, input logic vld,
                                  input cache_cmd_pkg::arb_out_req_t got,
                                  input cache_cmd_pkg::arb_out_req_t exp);
        if (vld !== 1'b1) begin
            fail_run($sformatf("Error: east_read_cmd_vld_out[%0d] got %h expected 1", lane, vld));
        end else if (got !== exp) begin
            fail_run($sformatf("Error: east_read_cmd_pld_out[%0d] got %h expected %h",
                               lane, got, exp));
        end
    endtask

    task automatic check_write_cmd(input int lane, input logic vld,
                                   input cache_cmd_pkg::write_ram_cmd_t got,
                                   input cache_cmd_pkg::write_ram_cmd_t exp);
        if (vld !== 1'b1) begin
            fail_run($sformatf("Error: east_write_cmd_vld_out[%0d] got %h expected 1", lane, vld));
        end else if (got !== exp) begin
            fail_run($sformatf("Error: east_write_cmd_pld_out[%0d] got %h expected %h",
                               lane, got, exp));
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int l = 0; l < `VC_LANES; l++) begin
                if (west_data_out_vld[l]) check_data(l, west_data_out[l]);
            end
            if (!east_open && ((east_read_cmd_vld_out | east_write_cmd_vld_out) != '0)) begin
                fail_run("a command left the east edge of the row unexpectedly");
            end
        end
    end

    task automatic put_write(input int lane, input fabric_route_pkg::ram_addr_u addr,
                             input logic [`VC_DATA_W-1:0] data);
        west_write_cmd_vld_in[lane]             = 1'b1;
        west_write_cmd_pld_in[lane].dest_ram_id = addr;
        west_write_cmd_pld_in[lane].wdata       = data;
        n_issued++;
        if (addr.route.col < `VC_BANKS) model[lane][addr.flat] = data;
    endtask

    task automatic put_read(input int lane, input fabric_route_pkg::ram_addr_u addr);
        cache_cmd_pkg::arb_out_req_t req;
        req.dest_ram_id = addr;
        req.tag         = `VC_TAG_W'(next_tag[lane]);
        next_tag[lane]++;
        west_read_cmd_vld_in[lane] = 1'b1;
        west_read_cmd_pld_in[lane] = req;
        n_issued++;
        if (addr.route.col < `VC_BANKS) begin
            exp_data[lane][req.tag] = model[lane][addr.flat];
            exp_pend[lane][req.tag] = 1'b1;
            outstanding++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
        west_read_cmd_vld_in  = '0;
        west_write_cmd_vld_in = '0;
    endtask

    task automatic wait_drained();
        while (outstanding != 0) @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic test_write_read_each_bank();
        for (int b = 0; b < `VC_BANKS; b++) begin
            for (int l = 0; l < `VC_LANES; l++) begin
                put_write(l, mk_addr(b, b + 1), `VC_DATA_W'($random(seed)));
            end
            step();
        end
        for (int b = 0; b < `VC_BANKS; b++) begin
            for (int l = 0; l < `VC_LANES; l++) put_read(l, mk_addr(b, b + 1));
            step();
        end
        wait_drained();
    endtask

    task automatic test_lane_isolation();
        logic [`VC_DATA_W-1:0] a;
        a = `VC_DATA_W'($random(seed));
        put_write(0, mk_addr(2, 9), a);
        put_write(1, mk_addr(2, 9), ~a);
        step();
        put_read(0, mk_addr(2, 9));
        put_read(1, mk_addr(2, 9));
        step();
        wait_drained();
    endtask

    task automatic test_overwrite();
        put_write(0, mk_addr(1, 3), `VC_DATA_W'($random(seed)));
        put_write(1, mk_addr(3, 0), `VC_DATA_W'($random(seed)));
        step();
        put_write(0, mk_addr(1, 3), `VC_DATA_W'($random(seed)));
        put_write(1, mk_addr(3, 0), `VC_DATA_W'($random(seed)));
        step();
        put_read(0, mk_addr(1, 3));
        put_read(1, mk_addr(3, 0));
        step();
        wait_drained();
    endtask

    task automatic test_out_of_row();
        cache_cmd_pkg::arb_out_req_t   rd_exp [`VC_LANES];
        cache_cmd_pkg::write_ram_cmd_t wr_exp [`VC_LANES];
        east_open = 1'b1;
        for (int l = 0; l < `VC_LANES; l++) begin
            put_read(l, mk_addr(`VC_BANKS + l, l + 2));
            put_write(l, mk_addr(7 - l, 9), `VC_DATA_W'($random(seed)));
            rd_exp[l] = west_read_cmd_pld_in[l];
            wr_exp[l] = west_write_cmd_pld_in[l];
        end
        step();
        repeat (2 * `VC_BANKS - 1) @(posedge clk);  // 2 cycles per bank
        #2;
        for (int l = 0; l < `VC_LANES; l++) begin
            check_read_cmd(l, east_read_cmd_vld_out[l], east_read_cmd_pld_out[l], rd_exp[l]);
            check_write_cmd(l, east_write_cmd_vld_out[l], east_write_cmd_pld_out[l], wr_exp[l]);
        end
        @(posedge clk);
        #2;
        east_open = 1'b0;
        repeat (3 + 4 * `VC_BANKS) @(posedge clk);  // room for a stray response
        #2;
    endtask

    task automatic test_merge_traffic();
        for (int c = `VC_BANKS - 1; c >= 0; c--) begin
            for (int k = 0; k < `VC_MERGE_DEPTH; k++) begin
                for (int l = 0; l < `VC_LANES; l++) begin
                    put_write(l, mk_addr(c, `VC_WORDS - `VC_MERGE_DEPTH + k),
                              `VC_DATA_W'($random(seed)));
                end
                step();
            end
        end
        // each burst meets the burst of the next column east in the switch
        for (int c = `VC_BANKS - 1; c >= 0; c--) begin
            for (int k = 0; k < `VC_MERGE_DEPTH; k++) begin
                for (int l = 0; l < `VC_LANES; l++) begin
                    put_read(l, mk_addr(c, `VC_WORDS - `VC_MERGE_DEPTH + k));
                end
                step();
            end
        end
        wait_drained();
    endtask

    initial begin
        rst_n                 = 1'b0;
        west_read_cmd_vld_in  = '0;
        west_write_cmd_vld_in = '0;
        for (int l = 0; l < `VC_LANES; l++) begin
            west_read_cmd_pld_in[l]  = '0;
            west_write_cmd_pld_in[l] = '0;
            next_tag[l]              = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_write_read_each_bank();
        test_lane_isolation();
        test_overwrite();
        test_out_of_row();
        test_merge_traffic();

        if (outstanding != 0) begin
            fail_run($sformatf("%0d read responses never arrived", outstanding));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vector_cache_row.f
+incdir+logic
logic/fabric_route_pkg.sv
logic/cache_cmd_pkg.sv
logic/mem_block.sv
logic/xy_switch.sv
logic/sram_bank.sv
logic/vector_cache_row.sv
test/vector_cache_row_assert.sv
test/vector_cache_row_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vector_cache_row_tb
SEED      ?= 1
FILELIST  ?= vector_cache_row.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero on $fatal or a failed assertion
run: $(BIN)
	$(BIN) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
